//--- common/synctimer_consts.svh
`ifndef SYNCTIMER_CONSTS_SVH
`define SYNCTIMER_CONSTS_SVH

// ----------------------------------------------------------------------
// timer format and rate
// ----------------------------------------------------------------------
`define TIMER_WIDTH        64     // bits of time of day
`define TIMER_NUMERATOR    10     // increment per clock is num/den
`define TIMER_DENOMINATOR  3

// ----------------------------------------------------------------------
// correction limits
// ----------------------------------------------------------------------
`define ADJ_LIMIT          4096   // larger error forces a load
`define ADJ_STEP_MAX       64     // step clamp for both signs
`define ADJ_GAIN_PHASE     2      // error >>> gain gives the step

`endif

//--- common/timer_pkg.sv
`include "synctimer_consts.svh"

package timer_pkg;

    // time of day as an unsigned count of time units
    typedef logic [`TIMER_WIDTH-1:0] timer_t;

    // remainder in units of 1/denominator
    typedef logic [7:0] frac_t;

endpackage

//--- common/adjust_pkg.sv
package adjust_pkg;

    typedef enum logic [1:0] {
        st_idle,
        st_calc,
        st_apply
    } adj_state_e;

    typedef enum logic [1:0] {
        op_none,
        op_load,
        op_step
    } adj_op_e;

    // phase step applied on top of the normal advance
    typedef logic signed [31:0] step_t;

endpackage

//--- common/timer_adj_if.sv
`timescale 1ns/1ps

interface timer_adj_if;
    import timer_pkg::*;
    import adjust_pkg::*;

    logic   load_valid;   // replace time, clear fraction
    timer_t load_time;
    logic   step_valid;   // one-shot phase step
    step_t  step_value;
    timer_t now_time;     // counter value back to adjuster

    modport adjuster (
        output load_valid,
        output load_time,
        output step_valid,
        output step_value,
        input  now_time
    );

    modport counter (
        input  load_valid,
        input  load_time,
        input  step_valid,
        input  step_value,
        output now_time
    );

endinterface

//--- rtl/correct_rx.sv
`timescale 1ns/1ps

module correct_rx (
    input  logic              ref_clk,
    input  logic              reset,
    input  logic              corr_req,
    input  timer_pkg::timer_t corr_time,
    input  logic              corr_override,
    output logic              corr_ack,
    output logic              rx_valid,
    output timer_pkg::timer_t rx_time,
    output logic              rx_override,
    input  logic              rx_ready
);

    logic req_meta;
    logic req_sync;
    logic req_rise;

    // first cycle the synchronized request reads high
    assign req_rise = req_meta && !req_sync;

    // ------------------------------------------------------------------
    // request synchronizer and ack side of the handshake
    // ------------------------------------------------------------------
    always_ff @(posedge ref_clk) begin
        if (reset) begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
            rx_valid <= 1'b0;
            corr_ack <= 1'b0;
        end else begin
            req_meta <= corr_req;
            req_sync <= req_meta;

            if (req_rise) begin
                rx_valid <= 1'b1;
            end else if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end

            if (rx_valid && rx_ready) begin
                corr_ack <= 1'b1;   // accepted by adjuster
            end else if (corr_ack && !req_sync) begin
                corr_ack <= 1'b0;   // master has let go
            end
        end
    end

    // master holds data stable while req is high
    always_ff @(posedge ref_clk) begin
        if (req_rise) begin
            rx_time     <= corr_time;
            rx_override <= corr_override;
        end
    end

endmodule

//--- synctimer/synctimer_adjust.sv
`timescale 1ns/1ps
`include "synctimer_consts.svh"

module synctimer_adjust (
    input  logic              ref_clk,
    input  logic              reset,
    input  logic              set_valid,
    input  timer_pkg::timer_t set_time,
    input  logic              rx_valid,
    input  timer_pkg::timer_t rx_time,
    input  logic              rx_override,
    output logic              rx_ready,
    timer_adj_if.adjuster     adj
);
    import timer_pkg::*;
    import adjust_pkg::*;

    adj_state_e state;
    adj_op_e    op;

    timer_t     tgt_time;     // time requested by set or master
    logic       force_load;   // set or override
    timer_t     now_smp;      // local time at accept
    step_t      step_q;

    logic signed [`TIMER_WIDTH-1:0] err;
    logic signed [`TIMER_WIDTH-1:0] err_shift;
    timer_t                         err_mag;
    logic                           over_limit;
    step_t                          step_calc;

    // local set wins over a pending correction
    assign rx_ready = (state == st_idle) && !set_valid;

    // ------------------------------------------------------------------
    // error and clamped phase step
    // ------------------------------------------------------------------
    always_comb begin
        err        = signed'(tgt_time - now_smp);
        err_mag    = err[`TIMER_WIDTH-1] ? timer_t'(-err) : timer_t'(err);
        over_limit = err_mag > timer_t'(`ADJ_LIMIT);
        err_shift  = err >>> `ADJ_GAIN_PHASE;
        if (err_shift > `ADJ_STEP_MAX) begin
            step_calc = step_t'(`ADJ_STEP_MAX);
        end else if (err_shift < -`ADJ_STEP_MAX) begin
            step_calc = step_t'(-`ADJ_STEP_MAX);
        end else begin
            step_calc = step_t'(err_shift);
        end
    end

    // ------------------------------------------------------------------
    // request FSM
    // ------------------------------------------------------------------
    always_ff @(posedge ref_clk) begin
        if (reset) begin
            state <= st_idle;
            op    <= op_none;
        end else begin
            case (state)
                st_idle: begin
                    op <= op_none;
                    if (set_valid || (rx_valid && rx_ready)) begin
                        state <= st_calc;
                    end
                end
                st_calc: begin
                    state <= st_apply;
                    op    <= (force_load || over_limit) ? op_load : op_step;
                end
                st_apply: begin
                    state <= st_idle;   // counter takes load or step here
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge ref_clk) begin
        if (state == st_idle) begin
            now_smp    <= adj.now_time;
            tgt_time   <= set_valid ? set_time : rx_time;
            force_load <= set_valid || rx_override;
        end
        if (state == st_calc) begin
            step_q <= step_calc;
        end
    end

    assign adj.load_valid = (state == st_apply) && (op == op_load);
    assign adj.load_time  = tgt_time;
    assign adj.step_valid = (state == st_apply) && (op == op_step);
    assign adj.step_value = step_q;

endmodule

//--- synctimer/synctimer_counter.sv
`timescale 1ns/1ps
`include "synctimer_consts.svh"

module synctimer_counter (
    input  logic              ref_clk,
    input  logic              reset,
    timer_adj_if.counter      adj,
    output timer_pkg::timer_t current_time
);
    import timer_pkg::*;

    timer_t time_q;
    frac_t  frac_q;

    logic [8:0]                     frac_sum;
    logic [8:0]                     carry;
    frac_t                          frac_next;
    logic signed [`TIMER_WIDTH-1:0] step_ext;

    // numerator/denominator per clock with exact remainder
    assign frac_sum  = {1'b0, frac_q} + 9'(`TIMER_NUMERATOR);
    assign carry     = frac_sum / 9'(`TIMER_DENOMINATOR);
    assign frac_next = frac_t'(frac_sum % 9'(`TIMER_DENOMINATOR));

    always_comb begin
        step_ext = '0;
        if (adj.step_valid) begin
            step_ext = adj.step_value;   // sign extended
        end
    end

    // ------------------------------------------------------------------
    // time of day
    // ------------------------------------------------------------------
    always_ff @(posedge ref_clk) begin
        if (reset) begin
            time_q <= '0;
            frac_q <= '0;
        end else if (adj.load_valid) begin
            time_q <= adj.load_time;
            frac_q <= '0;
        end else begin
            time_q <= time_q + timer_t'(carry) + timer_t'(step_ext);
            frac_q <= frac_next;
        end
    end

    assign adj.now_time  = time_q;
    assign current_time  = time_q;

endmodule

//--- rtl/synctimer_top.sv
`timescale 1ns/1ps

module synctimer_top (
    input  logic              ref_clk,
    input  logic              reset,

    input  logic              corr_req,
    input  timer_pkg::timer_t corr_time,
    input  logic              corr_override,
    output logic              corr_ack,

    input  logic              set_valid,
    input  timer_pkg::timer_t set_time,

    output timer_pkg::timer_t current_time
);

    logic              rx_valid;
    timer_pkg::timer_t rx_time;
    logic              rx_override;
    logic              rx_ready;

    timer_adj_if u_adj_if ();

    // master handshake into ref_clk domain
    correct_rx u_correct_rx (
        .ref_clk       (ref_clk),
        .reset         (reset),
        .corr_req      (corr_req),
        .corr_time     (corr_time),
        .corr_override (corr_override),
        .corr_ack      (corr_ack),
        .rx_valid      (rx_valid),
        .rx_time       (rx_time),
        .rx_override   (rx_override),
        .rx_ready      (rx_ready)
    );

    synctimer_adjust u_adjust (
        .ref_clk     (ref_clk),
        .reset       (reset),
        .set_valid   (set_valid),
        .set_time    (set_time),
        .rx_valid    (rx_valid),
        .rx_time     (rx_time),
        .rx_override (rx_override),
        .rx_ready    (rx_ready),
        .adj         (u_adj_if.adjuster)
    );

    synctimer_counter u_counter (
        .ref_clk      (ref_clk),
        .reset        (reset),
        .adj          (u_adj_if.counter),
        .current_time (current_time)
    );

endmodule

//--- testbench/tb_synctimer.sv
`timescale 1ns/1ps
`include "synctimer_consts.svh"

module tb_synctimer;
    import timer_pkg::*;

    localparam int ACK_TIMEOUT = 16;   // edges

    logic   ref_clk;
    logic   reset;
    logic   corr_req;
    timer_t corr_time;
    logic   corr_override;
    logic   corr_ack;
    logic   set_valid;
    timer_t set_time;
    timer_t current_time;

    // reference model state
    timer_t                         model_time;
    timer_t                         model_prev;   // time before the last edge
    int unsigned                    model_frac;
    int unsigned                    edge_cnt;
    logic                           pend_valid;
    logic                           pend_load;
    int unsigned                    pend_edge;
    timer_t                         pend_time;
    logic signed [`TIMER_WIDTH-1:0] pend_step;

    integer seed;
    integer fd;
    integer tests_run;

    synctimer_top UUT (
        .ref_clk       (ref_clk),
        .reset         (reset),
        .corr_req      (corr_req),
        .corr_time     (corr_time),
        .corr_override (corr_override),
        .corr_ack      (corr_ack),
        .set_valid     (set_valid),
        .set_time      (set_time),
        .current_time  (current_time)
    );

    initial ref_clk = 1'b0;
    always #10 ref_clk = ~ref_clk;

    // ----------------------------------------------------------------------
    // checks and failures
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [`TIMER_WIDTH-1:0] expected,
                               input logic [`TIMER_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    // model follows each rising edge and checks at the falling edge
    task automatic advance_cycle();
        int unsigned sum;
        @(negedge ref_clk);
        edge_cnt   = edge_cnt + 1;
        model_prev = model_time;
        sum        = model_frac + `TIMER_NUMERATOR;
        if (pend_valid && pend_edge == edge_cnt && pend_load) begin
            model_time = pend_time;   // load clears the fraction
            model_frac = 0;
            pend_valid = 1'b0;
        end else begin
            model_time = model_time + timer_t'(sum / `TIMER_DENOMINATOR);
            model_frac = sum % `TIMER_DENOMINATOR;
            if (pend_valid && pend_edge == edge_cnt) begin
                model_time = model_time + timer_t'(pend_step);
                pend_valid = 1'b0;
            end
        end
        check_value("current_time", model_time, current_time);
    endtask

    task automatic schedule_action(input logic load, input timer_t t,
                                   input logic signed [`TIMER_WIDTH-1:0] step);
        pend_valid = 1'b1;
        pend_load  = load;
        pend_edge  = edge_cnt + 2;   // applied at E2
        pend_time  = t;
        pend_step  = step;
    endtask

    task automatic idle_gap(input integer cycles);
        repeat (cycles) begin
            advance_cycle();
            check_value("corr_ack", 1'b0, corr_ack);
        end
    endtask

    // ----------------------------------------------------------------------
    // requests
    // ----------------------------------------------------------------------
    task automatic run_set(input timer_t t);
        set_time  = t;
        set_valid = 1'b1;
        advance_cycle();        // E0 samples set_valid
        set_valid = 1'b0;
        schedule_action(1'b1, t, '0);
    endtask

    task automatic run_correction(input timer_t t, input logic ovr);
        integer                         wait_cnt;
        logic signed [`TIMER_WIDTH-1:0] err;
        logic signed [`TIMER_WIDTH-1:0] mag;
        logic signed [`TIMER_WIDTH-1:0] step;
        corr_time     = t;
        corr_override = ovr;
        corr_req      = 1'b1;
        wait_cnt      = 0;
        while (corr_ack !== 1'b1) begin
            if (wait_cnt == ACK_TIMEOUT) begin
                fail_now("timeout: corr_ack never rose after corr_req");
            end else begin
                advance_cycle();
                wait_cnt = wait_cnt + 1;
            end
        end
        // error against local time just before the accepting edge
        err = signed'(t - model_prev);
        mag = (err < 0) ? -err : err;
        if (ovr || mag > `ADJ_LIMIT) begin
            schedule_action(1'b1, t, '0);
        end else begin
            step = err >>> `ADJ_GAIN_PHASE;
            if (step > `ADJ_STEP_MAX) begin
                step = `ADJ_STEP_MAX;
            end else if (step < -`ADJ_STEP_MAX) begin
                step = -`ADJ_STEP_MAX;
            end
            schedule_action(1'b0, '0, step);
        end
        corr_req = 1'b0;
        advance_cycle();
        check_value("corr_ack", 1'b1, corr_ack);   // req drop not yet synchronized
        wait_cnt = 0;
        while (corr_ack !== 1'b0) begin
            if (wait_cnt == ACK_TIMEOUT) begin
                fail_now("timeout: corr_ack never fell after corr_req dropped");
            end else begin
                advance_cycle();
                wait_cnt = wait_cnt + 1;
            end
        end
    endtask

    task automatic run_test_file();
        integer                         n;
        logic [7:0]                     kind;
        logic signed [`TIMER_WIDTH-1:0] value;
        integer                         ovr;
        integer                         gap;
        logic [8*200-1:0]               skip_line;
        n = $fscanf(fd, " %c", kind);
        while (n == 1) begin
            if (kind == "#") begin
                n = $fgets(skip_line, fd);   // comment line
            end else begin
                n = $fscanf(fd, " %d %d %d", value, ovr, gap);
                if (n != 3) begin
                    fail_now("malformed line in test file");
                end else begin
                    case (kind)
                        "s": run_set(value);
                        "c": run_correction(value, ovr[0]);
                        "d": run_correction(model_time + value, ovr[0]);
                        default: fail_now("unknown test kind in test file");
                    endcase
                    idle_gap(gap);
                    tests_run = tests_run + 1;
                end
            end
            n = $fscanf(fd, " %c", kind);
        end
        $fclose(fd);
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        integer                         offset;
        logic signed [`TIMER_WIDTH-1:0] off64;
        seed          = 32'hff7;
        reset         = 1'b1;
        corr_req      = 1'b0;
        corr_time     = '0;
        corr_override = 1'b0;
        set_valid     = 1'b0;
        set_time      = '0;
        model_time    = '0;
        model_prev    = '0;
        model_frac    = 0;
        edge_cnt      = 0;
        pend_valid    = 1'b0;
        pend_load     = 1'b0;
        pend_edge     = 0;
        pend_time     = '0;
        pend_step     = '0;
        tests_run     = 0;

        repeat (5) @(posedge ref_clk);
        @(negedge ref_clk);
        reset = 1'b0;
        check_value("current_time", '0, current_time);

        repeat (300) advance_cycle();   // free run at 10/3

        fd = $fopen("testbench/synctimer_tests.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open testbench/synctimer_tests.txt");
        end else begin
            run_test_file();
        end

        // small random corrections around local time
        repeat (8) begin
            offset = $random(seed) % 2000;
            off64  = offset;
            run_correction(model_time + off64, 1'b0);
            idle_gap(6);
        end

        if (tests_run == 0) begin
            fail_now("no tests read from test file");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- filelist.f
+incdir+common
common/timer_pkg.sv
common/adjust_pkg.sv
common/timer_adj_if.sv
rtl/correct_rx.sv
synctimer/synctimer_adjust.sv
synctimer/synctimer_counter.sv
rtl/synctimer_top.sv
testbench/tb_synctimer.sv

//--- testbench/synctimer_tests.txt
# columns: kind value override gap (idle cycles after the request)
# s = local set, c = correction at absolute time, d = correction at local time plus value
s 1000000 0 6
c 5000000000 1 8
d 40 0 8
d 100 0 8
d -50 0 8
# steps that clamp in both signs
d 1000 0 8
d -1000 0 8
d 4000 0 8
d -4000 0 8
# errors beyond the limit and overrides
d 5000 0 8
d -9000 0 8
d 30 1 8
c 123456789012345 0 8
s 0 0 6
d 200 0 8
